//--- build.f
logic/ahb_pkg.sv
logic/ahb_addr_decoder.sv
logic/ahb_default_slave.sv
logic/ahb_master_port.sv
logic/ahb_slave_arbiter.sv
logic/ahb_sram_slave.sv
logic/ahb_matrix_top.sv
tb/tb_ahb_matrix.sv

//--- logic/ahb_addr_decoder.sv
// per-master address decoder, turns an address phase into slave requests or a default-slave hit
`timescale 1ns/1ps

module ahb_addr_decoder (
  input  logic                             hclk,
  input  logic                             rst_n,
  input  ahb_pkg::ahb_req_t                req,
  output logic [ahb_pkg::NUM_SLAVES-1:0]   hreq,
  output logic                             default_slv_sel
);

  logic [ahb_pkg::PAGE_WIDTH-1:0] page;
  logic [ahb_pkg::NUM_SLAVES-1:0] hit;
  logic                           active;

  // page number of the incoming address
  assign page   = req.haddr[ahb_pkg::AHB_ADDR_WIDTH-1:ahb_pkg::PAGE_LSB];
  assign active = (req.htrans != ahb_pkg::IDLE);

  // range compare per slave
  always_comb begin
    for (int s = 0; s < ahb_pkg::NUM_SLAVES; s++) begin
      hit[s] = (page >= ahb_pkg::SLV_PAGE_LO[s]) && (page < ahb_pkg::SLV_PAGE_HI[s]);
    end
  end

  // nothing requested while idle
  assign hreq            = active ? hit : '0;
  // unmapped region goes to default slave
  assign default_slv_sel = active && !(|hit);

  // overlapping map entries would break this
  a_hreq_onehot : assert property (@(posedge hclk) disable iff (!rst_n)
    $onehot0(hreq));

  a_hreq_vs_default : assert property (@(posedge hclk) disable iff (!rst_n)
    !((|hreq) && default_slv_sel));

endmodule

//--- logic/ahb_default_slave.sv
// default slave inside a master port, answers unmapped transfers with a two-cycle ERROR
`timescale 1ns/1ps

module ahb_default_slave (
  input  logic              hclk,
  input  logic              rst_n,
  input  logic              accept,
  output ahb_pkg::ahb_rsp_t rsp
);

  typedef enum logic [1:0] {
    DS_IDLE,
    DS_ERR1,
    DS_ERR2
  } ds_state_t;

  ds_state_t state, state_nxt;

  // ERR2 is a completing cycle so a new accept may land there
  always_comb begin
    state_nxt = DS_IDLE;
    case (state)
      DS_IDLE: state_nxt = accept ? DS_ERR1 : DS_IDLE;
      DS_ERR1: state_nxt = DS_ERR2;
      DS_ERR2: state_nxt = accept ? DS_ERR1 : DS_IDLE;
      default: state_nxt = DS_IDLE;
    endcase
  end

  always_ff @(posedge hclk or negedge rst_n) begin
    if (!rst_n) begin
      state <= DS_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // first cycle stalls, second completes, both ERROR
  always_comb begin
    rsp = ahb_pkg::RSP_IDLE;
    case (state)
      DS_ERR1: rsp = '{hready: 1'b0, hresp: ahb_pkg::ERROR, hrdata: '0};
      DS_ERR2: rsp = '{hready: 1'b1, hresp: ahb_pkg::ERROR, hrdata: '0};
      default: rsp = ahb_pkg::RSP_IDLE;
    endcase
  end

  // master port must hold hready low through ERR1
  a_no_accept_in_err1 : assert property (@(posedge hclk) disable iff (!rst_n)
    (state == DS_ERR1) |-> !accept);

endmodule

//--- logic/ahb_master_port.sv
// master-side layer that tracks the data phase, drives hready and routes responses to one master
`timescale 1ns/1ps

module ahb_master_port (
  input  logic                                              hclk,
  input  logic                                              rst_n,
  input  ahb_pkg::ahb_req_t                                 m_req,
  output ahb_pkg::ahb_rsp_t                                 m_rsp,
  output logic              [ahb_pkg::NUM_SLAVES-1:0]       slv_req,
  input  logic              [ahb_pkg::NUM_SLAVES-1:0]       slv_gnt,
  input  ahb_pkg::ahb_rsp_t [ahb_pkg::NUM_SLAVES-1:0]       slv_rsp
);

  logic [ahb_pkg::NUM_SLAVES-1:0]     dec_req;
  logic                               dec_dflt;
  // owner of the pending data phase
  logic [ahb_pkg::NUM_SLAVES-1:0]     dp_slv;
  logic                               dp_dflt;
  // completed response parked while the next address waits
  logic                               held;
  ahb_pkg::hresp_t                    held_hresp;
  logic [ahb_pkg::AHB_DATA_WIDTH-1:0] held_hrdata;
  ahb_pkg::ahb_rsp_t                  dflt_rsp;
  ahb_pkg::ahb_rsp_t                  tgt_rsp;
  ahb_pkg::ahb_rsp_t                  cur_rsp;
  logic                               wait_gnt;
  logic                               accept;
  logic                               capture;

  ahb_addr_decoder u_dec (
    .hclk            (hclk),
    .rst_n           (rst_n),
    .req             (m_req),
    .hreq            (dec_req),
    .default_slv_sel (dec_dflt)
  );

  ahb_default_slave u_dflt (
    .hclk   (hclk),
    .rst_n  (rst_n),
    .accept (accept && dec_dflt),
    .rsp    (dflt_rsp)
  );

  // ==============================
  // response path
  // ==============================
  // default slave is idle OKAY unless it owns the data phase
  always_comb begin
    tgt_rsp = dflt_rsp;
    for (int s = 0; s < ahb_pkg::NUM_SLAVES; s++) begin
      if (dp_slv[s]) begin
        tgt_rsp = slv_rsp[s];
      end
    end
  end

  assign cur_rsp = held ?
                   ahb_pkg::ahb_rsp_t'{hready: 1'b1, hresp: held_hresp, hrdata: held_hrdata} :
                   tgt_rsp;

  // only ask for a slave once our own data phase can finish
  assign slv_req  = cur_rsp.hready ? dec_req : '0;
  // new address phase still without its grant
  assign wait_gnt = |(dec_req & ~slv_gnt);

  always_comb begin
    m_rsp        = cur_rsp;
    m_rsp.hready = cur_rsp.hready && !wait_gnt;
  end

  assign accept  = (m_req.htrans == ahb_pkg::NONSEQ) && m_rsp.hready;
  // slave finished but the master is stalled on a grant
  assign capture = !held && ((|dp_slv) || dp_dflt) && tgt_rsp.hready && !m_rsp.hready;

  // ==============================
  // data phase tracking
  // ==============================
  always_ff @(posedge hclk or negedge rst_n) begin
    if (!rst_n) begin
      dp_slv  <= '0;
      dp_dflt <= 1'b0;
      held    <= 1'b0;
    end else if (m_rsp.hready) begin
      dp_slv  <= accept ? dec_req : '0;
      dp_dflt <= accept && dec_dflt;
      held    <= 1'b0;
    end else if (capture) begin
      dp_slv  <= '0;
      dp_dflt <= 1'b0;
      held    <= 1'b1;
    end
  end

  always_ff @(posedge hclk) begin
    if (capture) begin
      held_hresp  <= tgt_rsp.hresp;
      held_hrdata <= tgt_rsp.hrdata;
    end
  end

endmodule

//--- logic/ahb_matrix_top.sv
// two-master, two-SRAM AHB-lite matrix, the top level that the testbench drives
`timescale 1ns/1ps

module ahb_matrix_top (
  input  logic                                          hclk,
  input  logic                                          rst_n,
  input  ahb_pkg::ahb_req_t [ahb_pkg::NUM_MASTERS-1:0]  m_req,
  output ahb_pkg::ahb_rsp_t [ahb_pkg::NUM_MASTERS-1:0]  m_rsp
);

  // master-port view, indexed [master][slave]
  logic              [ahb_pkg::NUM_MASTERS-1:0][ahb_pkg::NUM_SLAVES-1:0]  mp_req;
  logic              [ahb_pkg::NUM_MASTERS-1:0][ahb_pkg::NUM_SLAVES-1:0]  mp_gnt;
  ahb_pkg::ahb_rsp_t [ahb_pkg::NUM_MASTERS-1:0][ahb_pkg::NUM_SLAVES-1:0]  mp_rsp;
  // arbiter view, indexed [slave][master]
  logic              [ahb_pkg::NUM_SLAVES-1:0][ahb_pkg::NUM_MASTERS-1:0]  arb_req;
  logic              [ahb_pkg::NUM_SLAVES-1:0][ahb_pkg::NUM_MASTERS-1:0]  arb_gnt;
  ahb_pkg::ahb_rsp_t [ahb_pkg::NUM_SLAVES-1:0][ahb_pkg::NUM_MASTERS-1:0]  arb_rsp;
  ahb_pkg::ahb_req_t [ahb_pkg::NUM_SLAVES-1:0]                            s_req;
  ahb_pkg::ahb_rsp_t [ahb_pkg::NUM_SLAVES-1:0]                            s_rsp;

  // ==============================
  // crossbar wiring
  // ==============================
  for (genvar m = 0; m < ahb_pkg::NUM_MASTERS; m++) begin : g_mst
    ahb_master_port u_port (
      .hclk    (hclk),
      .rst_n   (rst_n),
      .m_req   (m_req[m]),
      .m_rsp   (m_rsp[m]),
      .slv_req (mp_req[m]),
      .slv_gnt (mp_gnt[m]),
      .slv_rsp (mp_rsp[m])
    );
    // transpose between master and slave indexing
    for (genvar s = 0; s < ahb_pkg::NUM_SLAVES; s++) begin : g_x
      assign arb_req[s][m] = mp_req[m][s];
      assign mp_gnt[m][s]  = arb_gnt[s][m];
      assign mp_rsp[m][s]  = arb_rsp[s][m];
    end
  end

  for (genvar s = 0; s < ahb_pkg::NUM_SLAVES; s++) begin : g_slv
    ahb_slave_arbiter u_arb (
      .hclk  (hclk),
      .rst_n (rst_n),
      .m_req (m_req),
      .req   (arb_req[s]),
      .gnt   (arb_gnt[s]),
      .m_rsp (arb_rsp[s]),
      .s_req (s_req[s]),
      .s_rsp (s_rsp[s])
    );

    ahb_sram_slave u_sram (
      .hclk  (hclk),
      .rst_n (rst_n),
      .req   (s_req[s]),
      .rsp   (s_rsp[s])
    );
  end

endmodule

//--- logic/ahb_pkg.sv
// shared AHB-lite types, bus widths and address map, referenced by scoped name from every block
package ahb_pkg;

  // ==============================
  // bus geometry
  // ==============================
  localparam int AHB_ADDR_WIDTH = 32;
  localparam int AHB_DATA_WIDTH = 32;
  localparam int NUM_MASTERS    = 2;
  localparam int NUM_SLAVES     = 2;
  // master index width for arbiter pointers
  localparam int MST_IDX_W      = $clog2(NUM_MASTERS);

  // ==============================
  // address map
  // ==============================
  // 1 KB pages
  localparam int PAGE_LSB   = 10;
  localparam int PAGE_WIDTH = AHB_ADDR_WIDTH - PAGE_LSB;
  // slave s owns pages lo <= page < hi
  // slave 0 at page 0, slave 1 at page 4
  localparam logic [NUM_SLAVES-1:0][PAGE_WIDTH-1:0] SLV_PAGE_LO = {22'd4, 22'd0};
  localparam logic [NUM_SLAVES-1:0][PAGE_WIDTH-1:0] SLV_PAGE_HI = {22'd5, 22'd1};

  // ==============================
  // transfer encodings
  // ==============================
  // only IDLE and NONSEQ are used
  typedef enum logic [1:0] {
    IDLE   = 2'd0,
    BUSY   = 2'd1,
    NONSEQ = 2'd2,
    SEQ    = 2'd3
  } htrans_t;

  typedef enum logic {
    OKAY  = 1'b0,
    ERROR = 1'b1
  } hresp_t;

  // address phase plus data phase write word, 67 bits
  typedef struct packed {
    htrans_t                   htrans;
    logic                      hwrite;
    logic [AHB_ADDR_WIDTH-1:0] haddr;
    logic [AHB_DATA_WIDTH-1:0] hwdata;
  } ahb_req_t;

  // slave response, 34 bits
  typedef struct packed {
    logic                      hready;
    hresp_t                    hresp;
    logic [AHB_DATA_WIDTH-1:0] hrdata;
  } ahb_rsp_t;

  // response seen when nobody owns the data phase
  localparam ahb_rsp_t RSP_IDLE = '{hready: 1'b1, hresp: OKAY, hrdata: '0};

endpackage

//--- logic/ahb_slave_arbiter.sv
// round-robin arbiter in front of one slave, shares it between the master ports
`timescale 1ns/1ps

module ahb_slave_arbiter (
  input  logic                                          hclk,
  input  logic                                          rst_n,
  input  ahb_pkg::ahb_req_t [ahb_pkg::NUM_MASTERS-1:0]  m_req,
  input  logic              [ahb_pkg::NUM_MASTERS-1:0]  req,
  output logic              [ahb_pkg::NUM_MASTERS-1:0]  gnt,
  output ahb_pkg::ahb_rsp_t [ahb_pkg::NUM_MASTERS-1:0]  m_rsp,
  output ahb_pkg::ahb_req_t                             s_req,
  input  ahb_pkg::ahb_rsp_t                             s_rsp
);

  // highest priority master
  logic [ahb_pkg::MST_IDX_W-1:0] ptr;
  logic [ahb_pkg::MST_IDX_W-1:0] win;
  logic                          any_req;
  // data phase owner
  logic                          dp_vld;
  logic [ahb_pkg::MST_IDX_W-1:0] dp_own;

  // ==============================
  // round-robin pick
  // ==============================
  // scan from ptr, nearest requester wins
  always_comb begin
    win     = ptr;
    any_req = 1'b0;
    for (int i = ahb_pkg::NUM_MASTERS - 1; i >= 0; i--) begin
      if (req[ptr + ahb_pkg::MST_IDX_W'(i)]) begin
        win     = ptr + ahb_pkg::MST_IDX_W'(i);
        any_req = 1'b1;
      end
    end
  end

  // slave must be able to take an address this cycle
  always_comb begin
    gnt = '0;
    if (any_req && s_rsp.hready) begin
      gnt[win] = 1'b1;
    end
  end

  always_ff @(posedge hclk or negedge rst_n) begin
    if (!rst_n) begin
      ptr    <= '0;
      dp_vld <= 1'b0;
      dp_own <= '0;
    end else begin
      // winner drops to lowest priority
      if (|gnt) begin
        ptr <= win + ahb_pkg::MST_IDX_W'(1);
      end
      if (s_rsp.hready) begin
        dp_vld <= |gnt;
        dp_own <= win;
      end
    end
  end

  // ==============================
  // slave side
  // ==============================
  // address from the winner, write data from the data phase owner
  always_comb begin
    s_req = m_req[win];
    if (!(|gnt)) begin
      s_req.htrans = ahb_pkg::IDLE;
    end
    s_req.hwdata = m_req[dp_own].hwdata;
  end

  // response only to the owner, the other master sees an idle bus
  always_comb begin
    for (int m = 0; m < ahb_pkg::NUM_MASTERS; m++) begin
      m_rsp[m] = ahb_pkg::RSP_IDLE;
      if (dp_vld && (dp_own == ahb_pkg::MST_IDX_W'(m))) begin
        m_rsp[m] = s_rsp;
      end
    end
  end

  a_gnt_onehot : assert property (@(posedge hclk) disable iff (!rst_n)
    $onehot0(gnt));

endmodule

//--- logic/ahb_sram_slave.sv
// zero-wait 256-word SRAM slave on the AHB-lite bus, cleared by reset
`timescale 1ns/1ps

module ahb_sram_slave (
  input  logic              hclk,
  input  logic              rst_n,
  input  ahb_pkg::ahb_req_t req,
  output ahb_pkg::ahb_rsp_t rsp
);

  logic [ahb_pkg::AHB_DATA_WIDTH-1:0] mem [256];
  // registered address phase
  logic                               dp_vld;
  logic                               dp_write;
  logic [7:0]                         dp_idx;

  // ==============================
  // address phase capture
  // ==============================
  // always ready, so every NONSEQ is taken
  always_ff @(posedge hclk or negedge rst_n) begin
    if (!rst_n) begin
      dp_vld   <= 1'b0;
      dp_write <= 1'b0;
    end else begin
      dp_vld   <= (req.htrans == ahb_pkg::NONSEQ);
      dp_write <= req.hwrite;
    end
  end

  // word index from haddr[9:2]
  always_ff @(posedge hclk) begin
    dp_idx <= req.haddr[9:2];
  end

  // ==============================
  // storage
  // ==============================
  // write lands at the end of the data phase
  always_ff @(posedge hclk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 256; i++) begin
        mem[i] <= '0;
      end
    end else if (dp_vld && dp_write) begin
      mem[dp_idx] <= req.hwdata;
    end
  end

  // read data straight from the array during the data phase
  always_comb begin
    rsp        = ahb_pkg::RSP_IDLE;
    rsp.hrdata = (dp_vld && !dp_write) ? mem[dp_idx] : '0;
  end

endmodule

//--- run.sh
#!/usr/bin/env bash
# build the AHB matrix testbench with Verilator, run it and judge the log
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -j 0 \
  --top-module tb_ahb_matrix --Mdir "$OBJ" -o tb_ahb_matrix -f build.f
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

"./$OBJ/tb_ahb_matrix" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "PASS: all tests" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1

//--- tb/ahb_golden.txt
# master write haddr hwdata exp_hrdata exp_hresp
# hex for haddr and data, hresp 0 is OKAY and 1 is ERROR
0 1 00000010 a5a50001 00000000 0
0 0 00000010 00000000 a5a50001 0
1 1 00001020 c3c30002 00000000 0
0 0 00001020 00000000 c3c30002 0
0 1 00000100 11110003 00000000 0
1 1 00000104 22220003 00000000 0
0 0 00000100 00000000 11110003 0
1 0 00000104 00000000 22220003 0
0 1 00000200 33330004 00000000 0
1 1 00001200 44440004 00000000 0
0 0 00000200 00000000 33330004 0
1 0 00001200 00000000 44440004 0
0 1 00001300 66660006 00000000 0
1 1 00000300 77770007 00000000 0
1 0 00001300 00000000 66660006 0
0 0 00000300 00000000 77770007 0
1 0 00000800 00000000 00000000 1
1 1 000003fc 55550005 00000000 0
1 0 000003fc 00000000 55550005 0
0 1 00000c00 88880008 00000000 1
0 0 00000044 00000000 00000000 0
1 0 000013fc 00000000 00000000 0

//--- tb/tb_ahb_matrix.sv
// testbench for the AHB matrix that replays tb/ahb_golden.txt on both masters and checks responses
`timescale 1ns/1ps

module tb_ahb_matrix;

  localparam int CLK_PERIOD = 40;
  localparam int RST_CYCLES = 2;

  // one transfer from the golden file
  typedef struct packed {
    logic        write;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic        hresp;
  } golden_t;

  logic                                         hclk;
  logic                                         rst_n;
  ahb_pkg::ahb_req_t [ahb_pkg::NUM_MASTERS-1:0] m_req;
  ahb_pkg::ahb_rsp_t [ahb_pkg::NUM_MASTERS-1:0] m_rsp;

  golden_t gold [$];
  // indices into gold, per master
  int      mst_q [ahb_pkg::NUM_MASTERS][$];
  bit      done_flag [$];
  bit      seq_done [ahb_pkg::NUM_MASTERS];
  bit      loaded;
  bit      start;
  bit      setup_err;
  int      pass_cnt;
  int      fail_cnt;

  ahb_matrix_top dut0 (
    .hclk  (hclk),
    .rst_n (rst_n),
    .m_req (m_req),
    .m_rsp (m_rsp)
  );

  initial hclk = 1'b0;
  always #(CLK_PERIOD / 2) hclk = ~hclk;

  // 32-bit xorshift step for idle gaps
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // ==============================
  // golden file, reset, summary
  // ==============================
  initial begin
    int          fd;
    int          n;
    int          m;
    int          w;
    int          rs;
    logic [31:0] a;
    logic [31:0] wd;
    logic [31:0] rd;
    string       line;
    rst_n <= 1'b0;
    fd = $fopen("tb/ahb_golden.txt", "r");
    if (fd == 0) begin
      $display("could not open tb/ahb_golden.txt");
      setup_err = 1'b1;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        // comment lines start with #
        if (line.len() == 0 || line.getc(0) == "#") continue;
        n = $sscanf(line, "%d %d %h %h %h %d", m, w, a, wd, rd, rs);
        if (n != 6) continue;
        if (m < 0 || m >= ahb_pkg::NUM_MASTERS) begin
          $display("golden line names master %0d, which does not exist", m);
          setup_err = 1'b1;
        end else begin
          mst_q[m].push_back(gold.size());
          gold.push_back('{write: w[0], addr: a, wdata: wd, rdata: rd, hresp: rs[0]});
          done_flag.push_back(1'b0);
        end
      end
      $fclose(fd);
      if (gold.size() == 0) begin
        $display("golden file holds no transfers");
        setup_err = 1'b1;
      end
    end
    loaded = 1'b1;
    repeat (RST_CYCLES) @(posedge hclk);
    rst_n <= 1'b1;
    start = 1'b1;
    wait (seq_done[0] && seq_done[1]);
    $display("summary: %0d passed, %0d failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && !setup_err) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // ==============================
  // one sequencer per master
  // ==============================
  for (genvar g = 0; g < ahb_pkg::NUM_MASTERS; g++) begin : g_seq
    initial begin
      int                k;
      int                gap;
      int                addr_waits;
      int                data_waits;
      bit                ok;
      logic [31:0]       rng;
      golden_t           e;
      ahb_pkg::ahb_rsp_t got;
      ahb_pkg::hresp_t   first_hresp;
      m_req[g] <= '0;
      rng = 32'hd845 ^ 32'(g);
      wait (start);
      for (int i = 0; i < mst_q[g].size(); i++) begin
        k = mst_q[g][i];
        e = gold[k];
        // earlier lines on the same address finish first
        for (int j = 0; j < k; j++) begin
          while (gold[j].addr == e.addr && !done_flag[j]) @(posedge hclk);
        end
        rng = xorshift32(rng);
        gap = int'(rng % 4);
        repeat (gap) @(posedge hclk);
        // address phase held until hready
        @(posedge hclk);
        m_req[g].htrans <= ahb_pkg::NONSEQ;
        m_req[g].hwrite <= e.write;
        m_req[g].haddr  <= e.addr;
        addr_waits = 0;
        @(negedge hclk);
        while (!m_rsp[g].hready) begin
          addr_waits++;
          @(posedge hclk);
          @(negedge hclk);
        end
        // data phase
        @(posedge hclk);
        m_req[g].htrans <= ahb_pkg::IDLE;
        m_req[g].hwdata <= e.wdata;
        data_waits = 0;
        @(negedge hclk);
        first_hresp = m_rsp[g].hresp;
        while (!m_rsp[g].hready) begin
          data_waits++;
          @(posedge hclk);
          @(negedge hclk);
        end
        got = m_rsp[g];
        ok  = 1'b1;
        assert (got.hresp == e.hresp) else begin
          $display("CHECK FAILED m%0d hresp: expected 0x%0h, got 0x%0h", g, e.hresp, got.hresp);
          ok = 1'b0;
        end
        // ERROR already shows in the stall cycle
        assert (first_hresp == e.hresp) else begin
          $display("CHECK FAILED m%0d first data cycle hresp: expected 0x%0h, got 0x%0h",
                   g, e.hresp, first_hresp);
          ok = 1'b0;
        end
        // losing master gets the bus one cycle later
        assert (addr_waits <= 1) else begin
          $display("m%0d address phase waited %0d cycles for a grant, at most 1 allowed",
                   g, addr_waits);
          ok = 1'b0;
        end
        // zero-wait for SRAM and one stall cycle for the default slave
        assert (data_waits == (e.hresp ? 1 : 0)) else begin
          $display("m%0d data phase took %0d wait cycles, expected %0d",
                   g, data_waits, e.hresp ? 1 : 0);
          ok = 1'b0;
        end
        // read data only means something on an OKAY read
        if (!e.write && !e.hresp) begin
          assert (got.hrdata == e.rdata) else begin
            $display("CHECK FAILED m%0d hrdata: expected 0x%08h, got 0x%08h",
                     g, e.rdata, got.hrdata);
            ok = 1'b0;
          end
        end
        $display("line %0d m%0d %s addr 0x%08h : %s", k, g, e.write ? "write" : "read",
                 e.addr, ok ? "ok" : "mismatch");
        if (ok) pass_cnt++;
        else fail_cnt++;
        done_flag[k] = 1'b1;
      end
      seq_done[g] = 1'b1;
    end
  end

  // ==============================
  // watchdog
  // ==============================
  // 12 cycles per golden line plus reset
  initial begin
    int unsigned limit_ns;
    wait (loaded);
    limit_ns = (gold.size() * 12 + RST_CYCLES + 2) * CLK_PERIOD;
    #(limit_ns);
    $display("timeout: transfers still pending after %0d ns", limit_ns);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule
